// ==== common/isaPkg.sv ====
package isaPkg;

	////////////////////
	// opcodes
	////////////////////

	// full 5-bit map, every code point is an instruction
	typedef enum logic [4:0] {
		// special
		opHalt  = 5'b00000,
		opNop   = 5'b00001,
		opSiic  = 5'b00010,
		opRti   = 5'b00011,
		// jumps
		opJ     = 5'b00100,
		opJr    = 5'b00101,
		opJal   = 5'b00110,
		opJalr  = 5'b00111,
		// i-format 1 alu with immediate
		opSubi  = 5'b01000,
		opAddi  = 5'b01001,
		opAndni = 5'b01010,
		opXori  = 5'b01011,
		// branches on rs
		opBnez  = 5'b01100,
		opBeqz  = 5'b01101,
		opBltz  = 5'b01110,
		opBgez  = 5'b01111,
		// memory and byte loads
		opSt    = 5'b10000,
		opLd    = 5'b10001,
		opSlbi  = 5'b10010,
		opStu   = 5'b10011,
		// shifts and rotates by immediate
		opRoli  = 5'b10100,
		opSlli  = 5'b10101,
		opRori  = 5'b10110,
		opSrli  = 5'b10111,
		// r-format
		opLbi   = 5'b11000,
		opBtr   = 5'b11001,
		opAlu2  = 5'b11010,
		opAlu1  = 5'b11011,
		opSeq   = 5'b11100,
		opSlt   = 5'b11101,
		opSle   = 5'b11110,
		opSco   = 5'b11111
	} opcodeE;

	// alu1 group codes; alu2 reads the same bits as rol, sll, ror, srl
	typedef enum logic [1:0] {
		fnAdd  = 2'b00,
		fnSub  = 2'b01,
		fnXor  = 2'b10,
		fnAndn = 2'b11
	} functE;

	////////////////////
	// instruction formats
	////////////////////

	typedef struct packed {
		opcodeE     opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		functE      funct;
	} rFmtT;

	typedef struct packed {
		opcodeE     opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm;
	} i1FmtT;

	typedef struct packed {
		opcodeE     opcode;
		logic [2:0] rs;
		logic [7:0] imm;
	} i2FmtT;

	typedef struct packed {
		opcodeE      opcode;
		logic [10:0] disp;
	} jFmtT;

	// one word, four views
	typedef union packed {
		rFmtT  r;
		i1FmtT i1;
		i2FmtT i2;
		jFmtT  j;
	} instrU;

	// immediate extension select
	typedef enum logic [2:0] {
		seZext5  = 3'b000,
		seZext8  = 3'b001,
		seSext5  = 3'b010,
		seSext8  = 3'b100,
		seSext11 = 3'b110
	} seSelE;

endpackage

// ==== common/ctrlPkg.sv ====
package ctrlPkg;
	import isaPkg::*;

	// where the destination index comes from
	typedef enum logic [1:0] {
		// r-format rd, bits 4:2
		dstRd   = 2'b00,
		// i-format 1 rd, bits 7:5
		dstRdI1 = 2'b01,
		// rs field, bits 10:8
		dstRs   = 2'b10,
		// link register
		dstR7   = 2'b11
	} regDstE;

	////////////////////
	// decoded control
	////////////////////

	typedef struct packed {
		regDstE regDst;
		seSelE  seSel;
		logic   regWrite;
		logic   dMemWrite;
		logic   dMemEn;
		// 1 picks rt, 0 picks the immediate
		logic   aluSrc2;
		logic   invA;
		logic   invB;
		logic   cin;
		logic   pcSrc;
		logic   pcImm;
		logic   branching;
		logic   jump;
		logic   memToReg;
		logic   dMemDump;
		logic   branchOrJump;
		// hazard hints for the later stages
		logic   readingRs;
		logic   readingRt;
		logic   writingToRs;
	} ctrlT;

	// instruction strobe from fetch
	typedef struct packed {
		logic  valid;
		instrU instr;
	} instrInT;

	// write-back strobe into the register file
	typedef struct packed {
		logic        valid;
		logic [2:0]  index;
		logic [15:0] data;
	} wbT;

	// registered result of the stage
	typedef struct packed {
		logic        valid;
		ctrlT        ctrl;
		logic        err;
		logic [15:0] rsData;
		logic [15:0] rtData;
		logic [15:0] imm;
		logic [2:0]  dstIndex;
	} decodeOutT;

endpackage

// ==== hw/control.sv ====
`timescale 1ns/1ps

module control import isaPkg::*, ctrlPkg::*; (
	input  opcodeE opcode,
	input  functE  funct,
	output ctrlT   ctrl,
	output logic   err
);

	always_comb begin
		// defaults: write a register, read rs and rt, alu takes rt
		ctrl = '0;
		ctrl.regWrite = 1'b1;
		ctrl.readingRs = 1'b1;
		ctrl.readingRt = 1'b1;
		ctrl.aluSrc2 = 1'b1;
		ctrl.regDst = dstRd;
		ctrl.seSel = seZext5;
		err = 1'b0;

		case (opcode)
			////////////////////
			// r-format
			////////////////////
			opAlu1: begin
				// sub is rt - rs, so rs is inverted with carry in
				case (funct)
					fnSub: begin
						ctrl.invA = 1'b1;
						ctrl.cin = 1'b1;
					end
					fnAndn: ctrl.invB = 1'b1;
					default: ctrl.regDst = dstRd;
				endcase
			end
			// shifts and carry-out need no operand tweaks
			opAlu2, opSco: ctrl.regDst = dstRd;
			// compares subtract rt from rs
			opSeq, opSlt, opSle: begin
				ctrl.invB = 1'b1;
				ctrl.cin = 1'b1;
			end
			// bit reverse of rs only
			opBtr: ctrl.readingRt = 1'b0;

			////////////////////
			// i-format 1
			////////////////////
			opSubi: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.invA = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.seSel = seSext5;
				ctrl.regDst = dstRdI1;
				ctrl.readingRt = 1'b0;
			end
			opAddi: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = seSext5;
				ctrl.regDst = dstRdI1;
				ctrl.readingRt = 1'b0;
			end
			opAndni: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.invB = 1'b1;
				ctrl.regDst = dstRdI1;
				ctrl.readingRt = 1'b0;
			end
			// logic and shift immediates stay zero extended
			opXori, opRoli, opSlli, opRori, opSrli: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.regDst = dstRdI1;
				ctrl.readingRt = 1'b0;
			end
			// store reads its data through the rt port (bits 7:5)
			opSt: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.regWrite = 1'b0;
				ctrl.seSel = seSext5;
				ctrl.dMemWrite = 1'b1;
				ctrl.dMemEn = 1'b1;
				ctrl.regDst = dstRdI1;
			end
			opLd: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = seSext5;
				ctrl.dMemEn = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regDst = dstRdI1;
				ctrl.readingRt = 1'b0;
			end
			// store with update writes the address back into rs
			opStu: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = seSext5;
				ctrl.dMemWrite = 1'b1;
				ctrl.dMemEn = 1'b1;
				ctrl.regDst = dstRs;
				ctrl.writingToRs = 1'b1;
			end

			////////////////////
			// i-format 2
			////////////////////
			opBnez, opBeqz, opBltz, opBgez: begin
				ctrl.seSel = seSext8;
				ctrl.pcSrc = 1'b1;
				ctrl.regWrite = 1'b0;
				ctrl.branching = 1'b1;
				ctrl.branchOrJump = 1'b1;
				ctrl.aluSrc2 = 1'b0;
				ctrl.readingRt = 1'b0;
			end
			// lbi overwrites rs without reading it
			opLbi: begin
				ctrl.seSel = seSext8;
				ctrl.regDst = dstRs;
				ctrl.aluSrc2 = 1'b0;
				ctrl.readingRs = 1'b0;
				ctrl.readingRt = 1'b0;
				ctrl.writingToRs = 1'b1;
			end
			opSlbi: begin
				ctrl.seSel = seZext8;
				ctrl.regDst = dstRs;
				ctrl.aluSrc2 = 1'b0;
				ctrl.readingRt = 1'b0;
				ctrl.writingToRs = 1'b1;
			end
			opJr, opJalr: begin
				ctrl.seSel = seSext8;
				ctrl.jump = 1'b1;
				ctrl.pcSrc = 1'b1;
				ctrl.aluSrc2 = 1'b0;
				ctrl.branchOrJump = 1'b1;
				ctrl.readingRt = 1'b0;
				// jalr links into r7, jr writes nothing
				ctrl.regWrite = (opcode == opJalr);
				ctrl.regDst = (opcode == opJalr) ? dstR7 : dstRd;
			end

			////////////////////
			// j-format
			////////////////////
			opJ, opJal: begin
				ctrl.seSel = seSext11;
				ctrl.pcImm = 1'b1;
				ctrl.pcSrc = 1'b1;
				ctrl.aluSrc2 = 1'b0;
				ctrl.branchOrJump = 1'b1;
				ctrl.readingRs = 1'b0;
				ctrl.readingRt = 1'b0;
				ctrl.regWrite = (opcode == opJal);
				ctrl.regDst = (opcode == opJal) ? dstR7 : dstRd;
			end

			// special instructions read no registers
			opSiic: begin
				ctrl.readingRs = 1'b0;
				ctrl.readingRt = 1'b0;
			end
			opNop, opHalt, opRti: begin
				ctrl.regWrite = 1'b0;
				ctrl.readingRs = 1'b0;
				ctrl.readingRt = 1'b0;
				// halt dumps memory, rti returns to epc
				ctrl.dMemDump = (opcode == opHalt);
				ctrl.pcSrc = (opcode == opRti);
			end

			// unknown code, flag it and block every side effect
			default: begin
				err = 1'b1;
				ctrl.regWrite = 1'b0;
				ctrl.dMemWrite = 1'b0;
				ctrl.dMemEn = 1'b0;
				ctrl.dMemDump = 1'b0;
			end
		endcase
	end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile import ctrlPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic [2:0]  rsIndex,
	input  logic [2:0]  rtIndex,
	output logic [15:0] rsData,
	output logic [15:0] rtData,
	input  wbT          wb
);

	// eight general purpose registers, r7 doubles as link
	logic [15:0] regs [8];

	// same-cycle write hits on each read port
	logic rsHit;
	logic rtHit;

	////////////////////
	// write port
	////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (wb.valid) begin
			regs[wb.index] <= wb.data;
		end
	end

	////////////////////
	// read ports
	////////////////////

	assign rsHit = wb.valid && (wb.index == rsIndex);
	assign rtHit = wb.valid && (wb.index == rtIndex);

	// write-before-read, a pending write wins over the stored value
	assign rsData = rsHit ? wb.data : regs[rsIndex];
	assign rtData = rtHit ? wb.data : regs[rtIndex];

endmodule

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import isaPkg::*, ctrlPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  instrInT   in,
	input  wbT        wb,
	output decodeOutT out
);

	// combinational decode of the incoming word
	ctrlT        ctrlD;
	logic        errD;
	logic [15:0] rsDataD;
	logic [15:0] rtDataD;
	logic [15:0] immD;
	logic [2:0]  dstD;

	// output register, control part is reset
	logic        validQ;
	ctrlT        ctrlQ;
	logic        errQ;
	// payload part only loads on a strobe
	logic [15:0] rsDataQ;
	logic [15:0] rtDataQ;
	logic [15:0] immQ;
	logic [2:0]  dstQ;

	control u_control (
		.opcode(in.instr.r.opcode),
		.funct (in.instr.r.funct),
		.ctrl  (ctrlD),
		.err   (errD)
	);

	// rs sits at 10:8 and rt at 7:5 in every format that reads them
	regFile u_regFile (
		.clk    (clk),
		.rstN   (rstN),
		.rsIndex(in.instr.r.rs),
		.rtIndex(in.instr.r.rt),
		.rsData (rsDataD),
		.rtData (rtDataD),
		.wb     (wb)
	);

	////////////////////
	// immediate and destination
	////////////////////

	always_comb begin
		case (ctrlD.seSel)
			seZext5:  immD = {11'b0, in.instr.i1.imm};
			seZext8:  immD = {8'b0, in.instr.i2.imm};
			seSext5:  immD = {{11{in.instr.i1.imm[4]}}, in.instr.i1.imm};
			seSext8:  immD = {{8{in.instr.i2.imm[7]}}, in.instr.i2.imm};
			seSext11: immD = {{5{in.instr.j.disp[10]}}, in.instr.j.disp};
			default:  immD = '0;
		endcase
	end

	always_comb begin
		case (ctrlD.regDst)
			dstRd:   dstD = in.instr.r.rd;
			dstRdI1: dstD = in.instr.i1.rd;
			dstRs:   dstD = in.instr.r.rs;
			default: dstD = 3'd7;
		endcase
	end

	////////////////////
	// output register
	////////////////////

	// valid follows the strobe, control holds between strobes
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validQ <= 1'b0;
			ctrlQ <= '0;
			errQ <= 1'b0;
		end else begin
			validQ <= in.valid;
			if (in.valid) begin
				ctrlQ <= ctrlD;
				errQ <= errD;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			rsDataQ <= rsDataD;
			rtDataQ <= rtDataD;
			immQ <= immD;
			dstQ <= dstD;
		end
	end

	always_comb begin
		out.valid = validQ;
		out.ctrl = ctrlQ;
		out.err = errQ;
		out.rsData = rsDataQ;
		out.rtData = rtDataQ;
		out.imm = immQ;
		out.dstIndex = dstQ;
	end

endmodule

// ==== dv/decode_assertions.sv ====
`timescale 1ns/1ps

module decode_assertions import ctrlPkg::*; (
	input logic      clk,
	input logic      rstN,
	input instrInT   in,
	input decodeOutT out
);

	// failures per property, summed for the testbench
	int validFails = 0;
	int memFails = 0;
	int errFails = 0;
	int failCount;

	assign failCount = validFails + memFails + errFails;

	// one cycle from strobe to bundle
	validFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> out.valid == $past(in.valid))
	else begin
		$error("out.valid differs from the strobe of the previous cycle");
		validFails++;
	end

	// a store always enables memory
	writeNeedsEnable: assert property (@(posedge clk) disable iff (!rstN)
		out.ctrl.dMemWrite |-> out.ctrl.dMemEn)
	else begin
		$error("dMemWrite set without dMemEn");
		memFails++;
	end

	// unknown opcode has no side effects
	errBlocksWrites: assert property (@(posedge clk) disable iff (!rstN)
		out.err |-> !out.ctrl.regWrite && !out.ctrl.dMemWrite)
	else begin
		$error("err set while a write is still enabled");
		errFails++;
	end

endmodule

bind decodeStage decode_assertions u_assertions (
	.clk (clk),
	.rstN(rstN),
	.in  (in),
	.out (out)
);

// ==== dv/decodeChecker.sv ====
`timescale 1ns/1ps

module decodeChecker import isaPkg::*, ctrlPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  instrInT   in,
	input  wbT        wb,
	input  decodeOutT out,
	input  int        testNum,
	input  logic      testEnd,
	output int        errorCount,
	output int        checkCount,
	output int        pending
);

	// model register file
	logic [15:0] mregs [8];
	// bundle expected after the next rising edge
	decodeOutT expOut;
	logic started = 1'b0;
	int pushCount = 0;
	int popCount = 0;
	int errors = 0;
	int checks = 0;
	// totals when the current test began
	int baseErrors = 0;
	int baseChecks = 0;

	assign pending = pushCount - popCount;
	assign errorCount = errors;
	assign checkCount = checks;

	////////////////////
	// reference model
	////////////////////

	// every code point of the map is defined
	function automatic logic modelErr(opcodeE op);
		return !(op inside {opHalt, opNop, opSiic, opRti, opJ, opJr, opJal, opJalr,
			opSubi, opAddi, opAndni, opXori, opBnez, opBeqz, opBltz, opBgez,
			opSt, opLd, opSlbi, opStu, opRoli, opSlli, opRori, opSrli,
			opLbi, opBtr, opAlu2, opAlu1, opSeq, opSlt, opSle, opSco});
	endfunction

	function automatic ctrlT modelCtrl(opcodeE op, functE fn);
		ctrlT c;
		logic link;
		logic viaReg;
		link = (op == opJal) || (op == opJalr);
		viaReg = (op == opJr) || (op == opJalr);
		// r-format baseline
		c = '0;
		c.regWrite = 1'b1;
		c.readingRs = 1'b1;
		c.readingRt = 1'b1;
		c.aluSrc2 = 1'b1;
		c.regDst = dstRd;
		c.seSel = seZext5;
		case (op)
			opAlu1: begin
				c.invA = (fn == fnSub);
				c.cin = (fn == fnSub);
				c.invB = (fn == fnAndn);
			end
			opSeq, opSlt, opSle: begin
				c.invB = 1'b1;
				c.cin = 1'b1;
			end
			opBtr: c.readingRt = 1'b0;
			// alu with immediate, only subi and addi sign extend
			opSubi, opAddi, opAndni, opXori, opRoli, opSlli, opRori, opSrli: begin
				c.aluSrc2 = 1'b0;
				c.readingRt = 1'b0;
				c.regDst = dstRdI1;
				c.invA = (op == opSubi);
				c.cin = (op == opSubi);
				c.invB = (op == opAndni);
				if (op == opSubi || op == opAddi)
					c.seSel = seSext5;
			end
			opSt, opLd, opStu: begin
				c.aluSrc2 = 1'b0;
				c.seSel = seSext5;
				c.dMemEn = 1'b1;
				c.dMemWrite = (op != opLd);
				c.memToReg = (op == opLd);
				c.regWrite = (op != opSt);
				c.readingRt = (op != opLd);
				c.regDst = (op == opStu) ? dstRs : dstRdI1;
				c.writingToRs = (op == opStu);
			end
			opBnez, opBeqz, opBltz, opBgez: begin
				c.seSel = seSext8;
				c.pcSrc = 1'b1;
				c.regWrite = 1'b0;
				c.branching = 1'b1;
				c.branchOrJump = 1'b1;
				c.aluSrc2 = 1'b0;
				c.readingRt = 1'b0;
			end
			opLbi, opSlbi: begin
				c.seSel = (op == opLbi) ? seSext8 : seZext8;
				c.regDst = dstRs;
				c.aluSrc2 = 1'b0;
				c.readingRs = (op == opSlbi);
				c.readingRt = 1'b0;
				c.writingToRs = 1'b1;
			end
			// register jumps take 8 bits, direct jumps 11
			opJ, opJal, opJr, opJalr: begin
				c.pcSrc = 1'b1;
				c.branchOrJump = 1'b1;
				c.aluSrc2 = 1'b0;
				c.readingRt = 1'b0;
				c.regWrite = link;
				c.regDst = link ? dstR7 : dstRd;
				c.readingRs = viaReg;
				c.jump = viaReg;
				c.pcImm = !viaReg;
				c.seSel = viaReg ? seSext8 : seSext11;
			end
			opSiic: begin
				c.readingRs = 1'b0;
				c.readingRt = 1'b0;
			end
			opHalt, opNop, opRti: begin
				c.regWrite = 1'b0;
				c.readingRs = 1'b0;
				c.readingRt = 1'b0;
				c.dMemDump = (op == opHalt);
				c.pcSrc = (op == opRti);
			end
			// alu2 and sco keep the baseline
			default: c.regDst = dstRd;
		endcase
		if (modelErr(op)) begin
			c.regWrite = 1'b0;
			c.dMemWrite = 1'b0;
			c.dMemEn = 1'b0;
			c.dMemDump = 1'b0;
		end
		return c;
	endfunction

	function automatic logic [15:0] modelImm(seSelE sel, instrU u);
		logic signed [4:0] s5;
		logic signed [7:0] s8;
		logic signed [10:0] s11;
		s5 = u.i1.imm;
		s8 = u.i2.imm;
		s11 = u.j.disp;
		case (sel)
			seSext5:  return 16'(s5);
			seSext8:  return 16'(s8);
			seSext11: return 16'(s11);
			seZext8:  return 16'(u.i2.imm);
			default:  return 16'(u.i1.imm);
		endcase
	endfunction

	function automatic logic [2:0] modelDst(regDstE sel, instrU u);
		case (sel)
			dstRd:   return u.r.rd;
			dstRdI1: return u.i1.rd;
			dstRs:   return u.i2.rs;
			default: return 3'd7;
		endcase
	endfunction

	// write-before-read on the model
	function automatic logic [15:0] readModel(logic [2:0] idx);
		if (wb.valid && wb.index == idx)
			return wb.data;
		return mregs[idx];
	endfunction

	function automatic string testName(int n);
		case (n)
			1:       return "reset";
			2:       return "register file";
			3:       return "control table";
			4:       return "immediate and destination";
			5:       return "opcode err sweep";
			default: return "streaming";
		endcase
	endfunction

	task automatic compareField(input string name, input logic [31:0] expV,
			input logic [31:0] gotV);
		checks++;
		if (gotV !== expV) begin
			errors++;
			$display("[ERROR] %s expected 0x%0h got 0x%0h (test %0d, %0t)",
				name, expV, gotV, testNum, $time);
		end
	endtask

	////////////////////
	// predict on the rising edge
	////////////////////

	always @(posedge clk) begin
		instrU u;
		ctrlT c;
		int testErrors;
		u = in.instr;
		if (!rstN) begin
			expOut = '0;
			for (int i = 0; i < 8; i++) begin
				mregs[i] = '0;
			end
		end else begin
			// valid tracks the strobe, control holds between strobes
			expOut.valid = in.valid;
			if (in.valid) begin
				c = modelCtrl(u.r.opcode, u.r.funct);
				expOut.ctrl = c;
				expOut.err = modelErr(u.r.opcode);
				expOut.rsData = readModel(u.r.rs);
				expOut.rtData = readModel(u.r.rt);
				expOut.imm = modelImm(c.seSel, u);
				expOut.dstIndex = modelDst(c.regDst, u);
				pushCount++;
			end
			if (wb.valid)
				mregs[wb.index] = wb.data;
		end
		started = 1'b1;
		if (testEnd) begin
			testErrors = errors - baseErrors;
			$display("test %0d %s: %s, %0d checks, %0d errors", testNum, testName(testNum),
				(testErrors == 0) ? "pass" : "FAIL", checks - baseChecks, testErrors);
			baseErrors = errors;
			baseChecks = checks;
		end
	end

	////////////////////
	// compare on the falling edge
	////////////////////

	always @(negedge clk) begin
		if (started) begin
			compareField("out.valid", 32'(expOut.valid), 32'(out.valid));
			compareField("out.ctrl", 32'(expOut.ctrl), 32'(out.ctrl));
			compareField("out.err", 32'(expOut.err), 32'(out.err));
			// payload only means something under valid
			if (expOut.valid) begin
				compareField("out.rsData", 32'(expOut.rsData), 32'(out.rsData));
				compareField("out.rtData", 32'(expOut.rtData), 32'(out.rtData));
				compareField("out.imm", 32'(expOut.imm), 32'(out.imm));
				compareField("out.dstIndex", 32'(expOut.dstIndex), 32'(out.dstIndex));
				popCount++;
			end
		end
	end

endmodule

// ==== dv/tbDecode.sv ====
`timescale 1ns/1ps

module tbDecode import isaPkg::*, ctrlPkg::*; ();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 10;
	localparam int unsigned randSeed = 32'h2b70_f844;

	// transactions per test
	localparam int nIdle = 5;
	localparam int nReg = 100;
	localparam int nOpcodes = 32;
	localparam int nFuncts = 4;
	localparam int nCtrlSweep = nOpcodes * nFuncts;
	localparam int nCtrlRand = 72;
	localparam int nImm = 150;
	localparam int nOpSweep = nOpcodes;
	localparam int nStream = 120;
	localparam int nTests = 6;
	localparam int nTotal = nIdle + nReg + nCtrlSweep + nCtrlRand + nImm + nOpSweep + nStream;
	// two clock periods per transaction, plus the reset
	localparam int watchdogNs = nTotal * clkPeriod * 2 + resetCycles * clkPeriod;

	logic      clk = 1'b0;
	logic      rstN;
	instrInT   inDrv;
	wbT        wbDrv;
	decodeOutT dutOut;

	// test sequencing shared with the checker
	int   testNum;
	logic testEnd;
	int   errorCount;
	int   checkCount;
	int   pending;
	int   assertFails;

	always #(clkPeriod / 2) clk = ~clk;

	decodeStage u_dut (
		.clk (clk),
		.rstN(rstN),
		.in  (inDrv),
		.wb  (wbDrv),
		.out (dutOut)
	);

	decodeChecker u_checker (
		.clk       (clk),
		.rstN      (rstN),
		.in        (inDrv),
		.wb        (wbDrv),
		.out       (dutOut),
		.testNum   (testNum),
		.testEnd   (testEnd),
		.errorCount(errorCount),
		.checkCount(checkCount),
		.pending   (pending)
	);

	////////////////////
	// stimulus helpers
	////////////////////

	// random word with a chosen opcode
	function automatic logic [15:0] wordWithOpcode(logic [4:0] op);
		instrU w;
		w = 16'($urandom);
		w.r.opcode = opcodeE'(op);
		return w;
	endfunction

	// one strobe on the falling edge, optional write-back alongside
	task automatic driveWord(input logic [15:0] word, input logic withWb,
			input logic [2:0] wbIndex);
		@(negedge clk);
		inDrv.valid = 1'b1;
		inDrv.instr = word;
		wbDrv.valid = withWb;
		wbDrv.index = wbIndex;
		wbDrv.data = 16'($urandom);
	endtask

	task automatic idleCycle();
		@(negedge clk);
		inDrv.valid = 1'b0;
		wbDrv.valid = 1'b0;
	endtask

	// let the last bundle drain, then mark the end of the test
	task automatic finishTest();
		idleCycle();
		@(posedge clk);
		wait (pending == 0);
		@(negedge clk);
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
		testNum = testNum + 1;
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		instrU w;
		logic [2:0] idx;
		void'($urandom(randSeed));
		rstN = 1'b0;
		inDrv = '0;
		wbDrv = '0;
		testNum = 1;
		testEnd = 1'b0;

		// reset, then idle with no strobe
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		repeat (nIdle) idleCycle();
		finishTest();

		// register file, a third of the writes land on rs in the same cycle
		for (int i = 0; i < nReg; i++) begin
			w = 16'($urandom);
			if ($urandom_range(0, 2) == 0)
				idx = w.r.rs;
			else
				idx = 3'($urandom);
			driveWord(w, 1'($urandom), idx);
		end
		finishTest();

		// control table, every opcode with every funct, then random
		for (int op = 0; op < nOpcodes; op++) begin
			for (int fn = 0; fn < nFuncts; fn++) begin
				w = wordWithOpcode(5'(op));
				w.r.funct = functE'(2'(fn));
				driveWord(w, 1'b0, 3'd0);
			end
		end
		for (int i = 0; i < nCtrlRand; i++) begin
			driveWord(wordWithOpcode(5'($urandom)), 1'($urandom), 3'($urandom));
		end
		finishTest();

		// immediate and destination on fully random words
		for (int i = 0; i < nImm; i++) begin
			driveWord(16'($urandom), 1'($urandom), 3'($urandom));
		end
		finishTest();

		// err flag across the whole opcode space
		for (int op = 0; op < nOpSweep; op++) begin
			driveWord(wordWithOpcode(5'(op)), 1'b0, 3'd0);
		end
		finishTest();

		// streaming with random gaps
		for (int i = 0; i < nStream; i++) begin
			repeat ($urandom_range(0, 1)) idleCycle();
			driveWord(16'($urandom), 1'($urandom), 3'($urandom));
		end
		finishTest();

		assertFails = u_dut.u_assertions.failCount;
		$display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			nTests, checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdogNs);
		$display("watchdog expired, the tests did not finish within %0d ns", watchdogNs);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== all.f ====
common/isaPkg.sv
common/ctrlPkg.sv
hw/control.sv
hw/regFile.sv
hw/decodeStage.sv
dv/decode_assertions.sv
dv/decodeChecker.sv
dv/tbDecode.sv

// ==== Makefile ====
TOP = tbDecode

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f common/*.sv hw/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Regression passed" sim.log; then echo "simulation gave no result"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module decodeStage \
		common/isaPkg.sv common/ctrlPkg.sv hw/control.sv hw/regFile.sv hw/decodeStage.sv

clean:
	rm -rf obj_dir sim.log
